// File: hdl/race_consts.svh
`ifndef RACE_CONSTS_SVH
`define RACE_CONSTS_SVH

// 640x480 at 25 MHz with horizontal counts in pixels
`define H_DISPLAY    640
`define H_SYNC_START 656
`define H_SYNC_END   751
`define H_TOTAL      800

// vertical in lines
`define V_DISPLAY    480
`define V_SYNC_START 490
`define V_SYNC_END   491
`define V_TOTAL      525

// car sprites are square
`define SPRITE_SIZE  16

// first hblank pixel of the row fetch window
`define LOAD_HPOS    640

// start positions
`define PLAYER_X0    312
`define PLAYER_Y0    400
`define ENEMY_X0     64
`define ENEMY_Y0     100

// player and enemy bounds
`define ROAD_MIN_X   64
`define ROAD_MAX_X   560
`define PLAYER_MIN_Y 16
`define PLAYER_MAX_Y 448

`define ENEMY_STEP   2 // enemy pixels per frame

`endif

// File: hdl/race_pkg.sv
package race_pkg;

	typedef logic [9:0] coord_t;      // screen x or y
	typedef logic [4:0] track_pos_t;  // stripe scroll phase
	typedef logic [7:0] sprite_row_t; // half-width car row
	typedef logic [3:0] row_idx_t;
	typedef logic [2:0] rgb_t;        // {blue, green, red}

	typedef struct packed {
		coord_t hpos;
		coord_t vpos;
		logic   display_on;
	} beam_t;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} joy_t;

	typedef struct packed {
		logic vstart; // first sprite line reached
		logic hstart; // sprite column reached on a sprite line
		logic load;   // row fetch window in hblank
	} sprite_strobe_t;

	typedef enum logic [2:0] {
		wait_v,
		wait_load,
		load,
		wait_h,
		draw
	} render_state_t;

	typedef enum logic {
		dir_right,
		dir_left
	} enemy_dir_t;

	// left half of the car with bit 7 at the outer edge
	localparam sprite_row_t car_rows [0:15] = '{
		8'b0000_0000,
		8'b0000_1110,
		8'b0011_1110,
		8'b0111_1100,
		8'b0111_0100,
		8'b0110_0000,
		8'b0011_0000,
		8'b0011_1000,
		8'b0001_1000,
		8'b0001_1000,
		8'b0011_1000,
		8'b0110_1110,
		8'b1110_1110,
		8'b1111_1110,
		8'b1110_1110,
		8'b0010_1100
	};

endpackage

// File: hdl/video_timing.sv
`timescale 1ns/100ps
`include "race_consts.svh"

module video_timing (
	input  logic            clk25mhz,
	input  logic            rst,
	output race_pkg::beam_t beam,
	output logic            hsync,
	output logic            vsync
);

	race_pkg::coord_t hcount;
	race_pkg::coord_t vcount;
	logic             line_end;
	logic             frame_end;
	logic             h_active;
	logic             v_active;

	assign line_end  = (hcount == race_pkg::coord_t'(`H_TOTAL - 1));
	assign frame_end = line_end && (vcount == race_pkg::coord_t'(`V_TOTAL - 1));

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 1'b1;
			end
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// sync levels decoded from the same count the beam shows
	assign hsync = (hcount >= race_pkg::coord_t'(`H_SYNC_START)) &&
		(hcount <= race_pkg::coord_t'(`H_SYNC_END));
	assign vsync = (vcount >= race_pkg::coord_t'(`V_SYNC_START)) &&
		(vcount <= race_pkg::coord_t'(`V_SYNC_END));

	assign h_active = (hcount < race_pkg::coord_t'(`H_DISPLAY));
	assign v_active = (vcount < race_pkg::coord_t'(`V_DISPLAY));

	assign beam = '{
		hpos:       hcount,
		vpos:       vcount,
		display_on: h_active && v_active
	};

endmodule

// File: hdl/sprite_renderer.sv
`timescale 1ns/100ps
`include "race_consts.svh"

module sprite_renderer (
	input  logic                     clk25mhz,
	input  logic                     rst,
	input  race_pkg::sprite_strobe_t strobe,
	output logic                     gfx,
	output logic                     busy
);

	localparam int unsigned xcount_w = $clog2(`SPRITE_SIZE);

	race_pkg::render_state_t state;
	race_pkg::row_idx_t      row_idx;  // bitmap row for the next line
	race_pkg::sprite_row_t   row_bits; // fetched row, held while drawing
	logic [xcount_w-1:0]     xcount;   // pixel within the line
	logic [2:0]              bit_sel;
	logic                    last_pixel;
	logic                    last_row;

	assign last_pixel = (xcount == xcount_w'(`SPRITE_SIZE - 1));
	assign last_row   = (row_idx == race_pkg::row_idx_t'(`SPRITE_SIZE - 1));

	// bits 7..0 on the left half, then 0..7 for the mirrored right half
	assign bit_sel = xcount[xcount_w-1] ? xcount[2:0] : ~xcount[2:0];

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			state   <= race_pkg::wait_v;
			row_idx <= '0;
			xcount  <= '0;
		end else begin
			case (state)
				race_pkg::wait_v: begin
					if (strobe.vstart) begin
						state   <= race_pkg::wait_load;
						row_idx <= '0;
					end
				end
				race_pkg::wait_load: begin
					if (strobe.load) begin
						state <= race_pkg::load;
					end
				end
				race_pkg::load: begin
					state <= race_pkg::wait_h; // row latched this cycle
				end
				race_pkg::wait_h: begin
					if (strobe.hstart) begin
						state  <= race_pkg::draw;
						xcount <= '0;
					end
				end
				race_pkg::draw: begin
					xcount <= xcount + 1'b1;
					if (last_pixel) begin
						if (last_row) begin
							state <= race_pkg::wait_v; // whole car done
						end else begin
							state   <= race_pkg::wait_load;
							row_idx <= row_idx + 1'b1;
						end
					end
				end
				default: begin
					state <= race_pkg::wait_v;
				end
			endcase
		end
	end

	// row fetch straight from the shared bitmap
	always_ff @(posedge clk25mhz) begin
		if (state == race_pkg::load) begin
			row_bits <= race_pkg::car_rows[row_idx];
		end
	end

	assign gfx  = (state == race_pkg::draw) && row_bits[bit_sel];
	assign busy = (state != race_pkg::wait_v);

endmodule

// File: hdl/race_control.sv
`timescale 1ns/100ps
`include "race_consts.svh"

module race_control (
	input  logic                     clk25mhz,
	input  logic                     rst,
	input  race_pkg::beam_t          beam,
	input  race_pkg::joy_t           joy,
	input  logic                     player_gfx,
	input  logic                     enemy_gfx,
	input  logic                     track_gfx,
	output race_pkg::sprite_strobe_t player_strobe,
	output race_pkg::sprite_strobe_t enemy_strobe,
	output race_pkg::track_pos_t     track_pos,
	output logic                     crash
);

	race_pkg::coord_t     player_x;
	race_pkg::coord_t     player_y;
	race_pkg::coord_t     enemy_x;
	race_pkg::coord_t     enemy_next_x;
	race_pkg::enemy_dir_t enemy_dir;
	logic                 frame_end;
	logic                 load_window;
	logic                 hit;
	logic                 collision; // sticky within the current frame

	function automatic race_pkg::sprite_strobe_t sprite_strobes(
		input race_pkg::beam_t  b,
		input race_pkg::coord_t x,
		input race_pkg::coord_t y,
		input logic             in_load
	);
		race_pkg::sprite_strobe_t s;
		s.vstart = (b.vpos == y) && (b.hpos == '0);
		// rows are shown on lines y+1 .. y+16
		s.hstart = (b.hpos == x) && (b.vpos > y) &&
			(b.vpos <= y + race_pkg::coord_t'(`SPRITE_SIZE));
		s.load   = in_load;
		return s;
	endfunction

	// last pixel of the frame
	assign frame_end = (beam.hpos == race_pkg::coord_t'(`H_TOTAL - 1)) &&
		(beam.vpos == race_pkg::coord_t'(`V_TOTAL - 1));

	assign load_window = (beam.hpos >= race_pkg::coord_t'(`LOAD_HPOS)) &&
		(beam.hpos <= race_pkg::coord_t'(`LOAD_HPOS + 3));

	assign player_strobe = sprite_strobes(beam, player_x, player_y, load_window);
	assign enemy_strobe  = sprite_strobes(beam, enemy_x,
		race_pkg::coord_t'(`ENEMY_Y0), load_window); // enemy y never moves

	// first active input wins and a blocked direction means no move
	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			player_x <= race_pkg::coord_t'(`PLAYER_X0);
			player_y <= race_pkg::coord_t'(`PLAYER_Y0);
		end else if (frame_end) begin
			if (joy.left) begin
				if (player_x > race_pkg::coord_t'(`ROAD_MIN_X)) begin
					player_x <= player_x - 1'b1;
				end
			end else if (joy.right) begin
				if (player_x < race_pkg::coord_t'(`ROAD_MAX_X)) begin
					player_x <= player_x + 1'b1;
				end
			end else if (joy.up) begin
				if (player_y > race_pkg::coord_t'(`PLAYER_MIN_Y)) begin
					player_y <= player_y - 1'b1;
				end
			end else if (joy.down) begin
				if (player_y < race_pkg::coord_t'(`PLAYER_MAX_Y)) begin
					player_y <= player_y + 1'b1;
				end
			end
		end
	end

	assign enemy_next_x = (enemy_dir == race_pkg::dir_right) ?
		enemy_x + race_pkg::coord_t'(`ENEMY_STEP) :
		enemy_x - race_pkg::coord_t'(`ENEMY_STEP);

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			enemy_x   <= race_pkg::coord_t'(`ENEMY_X0);
			enemy_dir <= race_pkg::dir_right;
			track_pos <= '0;
		end else if (frame_end) begin
			enemy_x   <= enemy_next_x;
			track_pos <= track_pos + 1'b1; // stripes scroll one step
			if (enemy_next_x >= race_pkg::coord_t'(`ROAD_MAX_X)) begin
				enemy_dir <= race_pkg::dir_left;
			end else if (enemy_next_x <= race_pkg::coord_t'(`ROAD_MIN_X)) begin
				enemy_dir <= race_pkg::dir_right;
			end
		end
	end

	assign hit = player_gfx && (enemy_gfx || track_gfx);

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			collision <= 1'b0;
			crash     <= 1'b0;
		end else if (frame_end) begin
			crash     <= collision || hit; // report the frame just ended
			collision <= 1'b0;
		end else if (hit) begin
			collision <= 1'b1;
		end
	end

endmodule

// File: hdl/playfield_composer.sv
`timescale 1ns/100ps

module playfield_composer (
	input  race_pkg::beam_t      beam,
	input  race_pkg::track_pos_t track_pos,
	input  logic                 player_gfx,
	input  logic                 enemy_gfx,
	output logic                 track_gfx,
	output race_pkg::rgb_t       rgb
);

	logic offside;
	logic shoulder;
	logic red;
	logic green;
	logic blue;

	// offside is hpos below 64 or 576 to 639
	assign offside = (beam.hpos[9:6] == 4'd0) || (beam.hpos[9:6] == 4'd9);

	// 8-pixel shoulders at 56..63 and 576..583
	assign shoulder = (beam.hpos[9:3] == 7'd7) || (beam.hpos[9:3] == 7'd72);

	// stripes are gaps where the line pair matches the scroll phase
	assign track_gfx = offside && (beam.vpos[5:1] != track_pos);

	assign red   = beam.display_on && (player_gfx || enemy_gfx || shoulder);
	assign green = beam.display_on && (player_gfx || track_gfx);
	assign blue  = beam.display_on && (enemy_gfx || shoulder);

	assign rgb = {blue, green, red};

endmodule

// File: hdl/racing_game_top.sv
`timescale 1ns/100ps

module racing_game_top (
	input  logic           clk25mhz,
	input  logic           rst,
	input  race_pkg::joy_t joy,
	output logic           hsync,
	output logic           vsync,
	output race_pkg::rgb_t rgb,
	output logic           crash
);

	race_pkg::beam_t          beam;
	race_pkg::sprite_strobe_t player_strobe;
	race_pkg::sprite_strobe_t enemy_strobe;
	race_pkg::track_pos_t     track_pos;
	logic                     player_gfx;
	logic                     enemy_gfx;
	logic                     track_gfx;

	video_timing u_video_timing (
		.clk25mhz (clk25mhz),
		.rst      (rst),
		.beam     (beam),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	race_control u_race_control (
		.clk25mhz      (clk25mhz),
		.rst           (rst),
		.beam          (beam),
		.joy           (joy),
		.player_gfx    (player_gfx),
		.enemy_gfx     (enemy_gfx),
		.track_gfx     (track_gfx),
		.player_strobe (player_strobe),
		.enemy_strobe  (enemy_strobe),
		.track_pos     (track_pos),
		.crash         (crash)
	);

	sprite_renderer u_player_renderer (
		.clk25mhz (clk25mhz),
		.rst      (rst),
		.strobe   (player_strobe),
		.gfx      (player_gfx),
		.busy     ()
	);

	sprite_renderer u_enemy_renderer (
		.clk25mhz (clk25mhz),
		.rst      (rst),
		.strobe   (enemy_strobe),
		.gfx      (enemy_gfx),
		.busy     ()
	);

	playfield_composer u_playfield_composer (
		.beam       (beam),
		.track_pos  (track_pos),
		.player_gfx (player_gfx),
		.enemy_gfx  (enemy_gfx),
		.track_gfx  (track_gfx),
		.rgb        (rgb)
	);

endmodule

// File: verif/racing_game_asserts.sv
`timescale 1ns/100ps
`include "race_consts.svh"

module racing_game_asserts (
	input logic                    clk25mhz,
	input logic                    rst,
	input race_pkg::beam_t         beam,
	input logic                    hsync,
	input race_pkg::rgb_t          rgb,
	input logic                    crash,
	input race_pkg::render_state_t player_state,
	input race_pkg::render_state_t enemy_state
);

	int hsync_run;       // cycles of the current hsync pulse
	int player_draw_run;
	int enemy_draw_run;
	int fail_count = 0;  // failed properties so far

	always_ff @(posedge clk25mhz) begin
		if (rst) begin
			hsync_run       <= 0;
			player_draw_run <= 0;
			enemy_draw_run  <= 0;
		end else begin
			hsync_run       <= hsync ? hsync_run + 1 : 0;
			player_draw_run <= (player_state == race_pkg::draw) ? player_draw_run + 1 : 0;
			enemy_draw_run  <= (enemy_state == race_pkg::draw) ? enemy_draw_run + 1 : 0;
		end
	end

	hsync_width: assert property (@(posedge clk25mhz) disable iff (rst)
		(!hsync && hsync_run != 0) |-> (hsync_run == `H_SYNC_END - `H_SYNC_START + 1))
		else begin
			fail_count = fail_count + 1;
			$error("hsync pulse is not 96 cycles wide");
		end

	// blanking decoded from the beam counters themselves
	blank_black: assert property (@(posedge clk25mhz) disable iff (rst)
		(beam.hpos >= `H_DISPLAY || beam.vpos >= `V_DISPLAY) |-> (rgb == '0))
		else begin
			fail_count = fail_count + 1;
			$error("rgb is not black during blanking");
		end

	// crash only moves on the first pixel of a frame
	crash_hold: assert property (@(posedge clk25mhz) disable iff (rst)
		(beam.hpos != 0 || beam.vpos != 0) |-> $stable(crash))
		else begin
			fail_count = fail_count + 1;
			$error("crash changed away from the frame end");
		end

	player_draw_len: assert property (@(posedge clk25mhz) disable iff (rst)
		(player_state != race_pkg::draw && player_draw_run != 0) |->
		(player_draw_run == `SPRITE_SIZE))
		else begin
			fail_count = fail_count + 1;
			$error("player renderer draw is not 16 cycles");
		end

	enemy_draw_len: assert property (@(posedge clk25mhz) disable iff (rst)
		(enemy_state != race_pkg::draw && enemy_draw_run != 0) |->
		(enemy_draw_run == `SPRITE_SIZE))
		else begin
			fail_count = fail_count + 1;
			$error("enemy renderer draw is not 16 cycles");
		end

endmodule

bind racing_game_top racing_game_asserts u_racing_game_asserts (
	.clk25mhz     (clk25mhz),
	.rst          (rst),
	.beam         (beam),
	.hsync        (hsync),
	.rgb          (rgb),
	.crash        (crash),
	.player_state (u_player_renderer.state),
	.enemy_state  (u_enemy_renderer.state)
);

// File: verif/racing_game_tb.sv
`timescale 1ns/100ps
`include "race_consts.svh"

module racing_game_tb;

	localparam int n_frames       = 5;
	localparam int frame_cycles   = `H_TOTAL * `V_TOTAL;
	localparam int timeout_cycles = n_frames * frame_cycles + 100_000;

	logic           clk25mhz;
	logic           rst;
	race_pkg::joy_t joy;
	logic           hsync;
	logic           vsync;
	race_pkg::rgb_t rgb;
	logic           crash;

	integer seed   = 32'h59bf;
	int     rnd;
	int     cycles = 0;

	// model of beam and game state
	int m_h;
	int m_v;
	int frames;
	int px;
	int py;
	int ex;
	bit e_left; // enemy heading left
	int tpos;
	bit coll;   // collision seen in the current frame
	bit exp_crash;

	racing_game_top u_racing_game_top (
		.clk25mhz (clk25mhz),
		.rst      (rst),
		.joy      (joy),
		.hsync    (hsync),
		.vsync    (vsync),
		.rgb      (rgb),
		.crash    (crash)
	);

	initial begin
		clk25mhz = 1'b0;
		forever #20 clk25mhz = ~clk25mhz;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input int exp_val, input int act_val);
		stop_with_failure($sformatf("FAILED %s: expected %0h, actual %0h",
			test, exp_val, act_val));
	endtask

	// car pixel for a sprite placed at (x, y)
	function automatic bit car_pixel(int x, int y, int h, int v);
		race_pkg::row_idx_t    r;
		race_pkg::sprite_row_t row;
		logic [2:0]            idx;
		int                    c;
		if (v <= y || v > y + `SPRITE_SIZE || h <= x || h > x + `SPRITE_SIZE) begin
			return 1'b0;
		end
		r   = race_pkg::row_idx_t'(v - y - 1);
		c   = h - x - 1;
		idx = 3'((c < 8) ? 7 - c : c - 8); // right half is the mirror
		row = race_pkg::car_rows[r];
		return row[idx];
	endfunction

	function automatic bit track_pixel(int h, int v, int track);
		bit offside;
		offside = ((h >> 6) == 0) || ((h >> 6) == 9);
		return offside && (((v >> 1) & 31) != track);
	endfunction

	function automatic race_pkg::rgb_t expected_rgb(int h, int v, int player_x, int player_y,
		int enemy_x, int track);
		bit on;
		bit p;
		bit e;
		bit sh;
		bit trk;
		on  = (h < `H_DISPLAY) && (v < `V_DISPLAY);
		p   = car_pixel(player_x, player_y, h, v);
		e   = car_pixel(enemy_x, `ENEMY_Y0, h, v);
		sh  = ((h >> 3) == 7) || ((h >> 3) == 72); // shoulders
		trk = track_pixel(h, v, track);
		return {on && (e || sh), on && (p || trk), on && (p || e || sh)};
	endfunction

	// compare against the model and then step it
	always @(posedge clk25mhz) begin
		race_pkg::rgb_t exp_rgb;
		bit             exp_hs;
		bit             exp_vs;
		int             nx;
		if (rst) begin
			m_h       = 0;
			m_v       = 0;
			frames    = 0;
			px        = `PLAYER_X0;
			py        = `PLAYER_Y0;
			ex        = `ENEMY_X0;
			e_left    = 1'b0;
			tpos      = 0;
			coll      = 1'b0;
			exp_crash = 1'b0;
		end else begin
			exp_hs  = (m_h >= `H_SYNC_START) && (m_h <= `H_SYNC_END);
			exp_vs  = (m_v >= `V_SYNC_START) && (m_v <= `V_SYNC_END);
			exp_rgb = expected_rgb(m_h, m_v, px, py, ex, tpos);
			assert (hsync === exp_hs) else report_mismatch(
				$sformatf("hsync frame %0d at %0d,%0d", frames, m_h, m_v),
				int'(exp_hs), int'(hsync));
			assert (vsync === exp_vs) else report_mismatch(
				$sformatf("vsync frame %0d at %0d,%0d", frames, m_h, m_v),
				int'(exp_vs), int'(vsync));
			assert (rgb === exp_rgb) else report_mismatch(
				$sformatf("rgb frame %0d at %0d,%0d", frames, m_h, m_v),
				int'(exp_rgb), int'(rgb));
			assert (crash === exp_crash) else report_mismatch(
				$sformatf("crash after frame %0d", frames), int'(exp_crash), int'(crash));
			assert (u_racing_game_top.u_racing_game_asserts.fail_count == 0)
			else stop_with_failure("a bound timing or renderer assertion failed");
			if (car_pixel(px, py, m_h, m_v) &&
				(car_pixel(ex, `ENEMY_Y0, m_h, m_v) || track_pixel(m_h, m_v, tpos))) begin
				coll = 1'b1;
			end
			if (m_h == `H_TOTAL - 1 && m_v == `V_TOTAL - 1) begin
				exp_crash = coll;
				coll      = 1'b0;
				if (joy.left) begin
					if (px > `ROAD_MIN_X) px = px - 1;
				end else if (joy.right) begin
					if (px < `ROAD_MAX_X) px = px + 1;
				end else if (joy.up) begin
					if (py > `PLAYER_MIN_Y) py = py - 1;
				end else if (joy.down) begin
					if (py < `PLAYER_MAX_Y) py = py + 1;
				end
				nx = e_left ? ex - `ENEMY_STEP : ex + `ENEMY_STEP;
				ex = nx;
				if (nx >= `ROAD_MAX_X) begin
					e_left = 1'b1;
				end else if (nx <= `ROAD_MIN_X) begin
					e_left = 1'b0; // bounce off the left edge
				end
				tpos   = (tpos + 1) % 32;
				frames = frames + 1;
			end
			if (m_h == `H_TOTAL - 1) begin
				m_h = 0;
				m_v = (m_v == `V_TOTAL - 1) ? 0 : m_v + 1;
			end else begin
				m_h = m_h + 1;
			end
		end
	end

	always @(posedge clk25mhz) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			stop_with_failure("timeout: the run did not finish within the cycle limit");
		end
	end

	initial begin
		rst = 1'b1;
		joy = '0;
		repeat (16) @(posedge clk25mhz);
		@(negedge clk25mhz);
		rst = 1'b0;
		for (int f = 0; f < n_frames; f++) begin
			@(negedge clk25mhz);
			while (m_v != `V_TOTAL / 2) @(negedge clk25mhz);
			rnd = $random(seed);
			joy = rnd[3:0]; // held until the middle of the next frame
			while (frames <= f) @(negedge clk25mhz);
		end
		@(posedge clk25mhz);
		@(negedge clk25mhz); // last crash value checked
		if (u_racing_game_top.u_racing_game_asserts.fail_count != 0) begin
			stop_with_failure("a bound timing or renderer assertion failed");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/race_pkg.sv
hdl/video_timing.sv
hdl/sprite_renderer.sv
hdl/race_control.sv
hdl/playfield_composer.sv
hdl/racing_game_top.sv
verif/racing_game_asserts.sv
verif/racing_game_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = racing_game_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
